// ==== lpif_pkg.sv ====
// Link geometry and flit, payload and lane types shared by every adapter block
package lpif_pkg;

  //////////////////////////////////////////////////
  // Lane geometry

  localparam int LANE_COUNT = 4;
  localparam int LANE_WIDTH = 40;

  // Marker sits on the top bit of every lane
  localparam int MRK_BIT = 39;

  // Strobe lives in one lane only
  localparam int STB_LANE = 0;
  localparam int STB_BIT = 38;

  // 39 usable bits per lane, one less in the strobe lane
  localparam int PAYLOAD_WIDTH = 155;

  //////////////////////////////////////////////////
  // Flit fields

  localparam int DATA_WIDTH = 128;
  localparam int CRC_WIDTH = 16;

  // Online delay and strobe interval configuration width
  localparam int DELAY_WIDTH = 16;

  //////////////////////////////////////////////////
  // Types

  // One flit, 153 bits, MSB first in field order
  typedef struct packed {
    logic [3:0]            state;
    logic [1:0]            protid;
    logic [DATA_WIDTH-1:0] data;
    logic                  dvalid;
    logic [CRC_WIDTH-1:0]  crc;
    logic                  crc_valid;
    logic                  valid;
  } ll_word_t;

  // Flit in the low bits, spare bits on top stay zero
  typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

  // All PHY lanes, lane 0 in the low slice
  typedef logic [LANE_COUNT-1:0][LANE_WIDTH-1:0] phy_bus_t;

endpackage

// ==== ll_auto_sync.sv ====
// Online delay and marker/strobe generation; instantiated once in the adapter top
`timescale 1ns/1ns

module ll_auto_sync (
  input  logic                            clk_wr,
  input  logic                            rst_n,

  input  logic                            tx_online,
  input  logic                            rx_online,

  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_y_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_z_value,

  input  logic                            tx_mrk_userbit,
  input  logic                            tx_stb_userbit,

  output logic                            tx_online_delay,
  output logic                            rx_online_delay,
  output logic                            tx_auto_mrk_userbit,
  output logic                            tx_auto_stb_userbit
);

  import lpif_pkg::*;

  // Index 0 is the tx side, index 1 the rx side
  logic [1:0]                   online_in;
  logic [1:0][DELAY_WIDTH-1:0]  online_dly;
  logic [1:0][DELAY_WIDTH-1:0]  online_cnt;
  logic [1:0]                   online_q;

  logic [DELAY_WIDTH-1:0]       stb_period;
  logic [DELAY_WIDTH-1:0]       stb_cnt;

  //////////////////////////////////////////////////
  // Online delay counters

  assign online_in  = {rx_online, tx_online};
  assign online_dly = {delay_y_value, delay_x_value};

  // Saturating count of consecutive high samples, cleared by any low sample
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      online_cnt <= '0;
      online_q   <= '0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (!online_in[k]) begin
          online_cnt[k] <= '0;
          online_q[k]   <= 1'b0;
        end else if (online_cnt[k] >= online_dly[k]) begin
          online_q[k]   <= 1'b1;
        end else begin
          online_cnt[k] <= online_cnt[k] + 1'b1;
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  //////////////////////////////////////////////////
  // Strobe interval

  // Zero interval behaves as one, i.e. a strobe every cycle
  assign stb_period = (delay_z_value == '0) ? DELAY_WIDTH'(1) : delay_z_value;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      stb_cnt <= '0;
    end else if (!tx_online_delay) begin
      stb_cnt <= '0;
    end else if (stb_cnt >= stb_period - 1'b1) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  assign tx_auto_stb_userbit = tx_online_delay & tx_stb_userbit & (stb_cnt == '0);

  // Persistent marker on every word once online
  assign tx_auto_mrk_userbit = tx_online_delay & tx_mrk_userbit;

  //////////////////////////////////////////////////
  // Checks

  // Interval count starts fresh on the first online cycle
  a_stb_restart: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    $rose(tx_online_delay) |-> (stb_cnt == '0)
  ) else $error("strobe count not restarted at tx bring-up");

  a_no_rise_offline: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    $rose(tx_online_delay) |-> $past(tx_online)
  ) else $error("tx_online_delay rose without tx_online");

endmodule

// ==== llink_pack.sv ====
// Flit to lane-payload mapping and registered downstream flit; used by the adapter top
`timescale 1ns/1ns

module llink_pack (
  input  logic               clk_wr,
  input  logic               rst_n,

  input  logic               rx_online_delay,

  // Upstream flit in, payload out to the lanes
  input  lpif_pkg::ll_word_t ustrm,
  output lpif_pkg::payload_t tx_payload,

  // Payload from the lanes, downstream flit out
  input  lpif_pkg::payload_t rx_payload,
  output lpif_pkg::ll_word_t dstrm
);

  import lpif_pkg::*;

  localparam int FLIT_WIDTH  = $bits(ll_word_t);
  localparam int SPARE_WIDTH = PAYLOAD_WIDTH - FLIT_WIDTH;

  ll_word_t rx_word;
  ll_word_t rx_gated;

  //////////////////////////////////////////////////
  // Upstream

  // Flit goes straight into the low payload bits, no register here
  assign tx_payload = {{SPARE_WIDTH{1'b0}}, ustrm};

  //////////////////////////////////////////////////
  // Downstream

  // Spare top bits carry nothing
  assign rx_word = rx_payload[FLIT_WIDTH-1:0];

  // Only the qualifiers drop while rx is offline, fields pass through
  always_comb begin
    rx_gated           = rx_word;
    rx_gated.valid     = rx_word.valid & rx_online_delay;
    rx_gated.dvalid    = rx_word.dvalid & rx_online_delay;
    rx_gated.crc_valid = rx_word.crc_valid & rx_online_delay;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      dstrm <= '0;
    end else begin
      dstrm <= rx_gated;
    end
  end

  //////////////////////////////////////////////////
  // Checks

  // Spare bits must arrive as zero from the lanes
  a_rx_spare_zero: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    rx_payload[PAYLOAD_WIDTH-1:FLIT_WIDTH] == '0
  ) else $error("spare payload bits set on receive");

endmodule

// ==== lane_stripe.sv ====
// Payload and userbit striping over the PHY lanes with tx and rx lane registers
`timescale 1ns/1ns

module lane_stripe (
  input  logic               clk_wr,
  input  logic               rst_n,

  input  logic               tx_online_delay,
  input  logic               tx_stb_userbit,
  input  logic               tx_mrk_userbit,

  input  lpif_pkg::payload_t tx_payload,
  output lpif_pkg::phy_bus_t tx_phy,

  input  lpif_pkg::phy_bus_t rx_phy,
  output lpif_pkg::payload_t rx_payload
);

  import lpif_pkg::*;

  phy_bus_t              tx_lanes;
  phy_bus_t              rx_lanes_q;
  logic [LANE_COUNT-1:0] rx_mrk;

  // True for lane bits reserved for marker or strobe
  function automatic logic is_userbit(input int lane, input int bit_idx);
    return (bit_idx == MRK_BIT) || (lane == STB_LANE && bit_idx == STB_BIT);
  endfunction

  //////////////////////////////////////////////////
  // Transmit

  // Payload fills lane 0 upward, skipping the userbit slots
  always_comb begin
    int p;
    p = 0;
    tx_lanes = '0;
    for (int i = 0; i < LANE_COUNT; i++) begin
      for (int b = 0; b < LANE_WIDTH; b++) begin
        if (b == MRK_BIT) begin
          tx_lanes[i][b] = tx_mrk_userbit;
        end else if (is_userbit(i, b)) begin
          tx_lanes[i][b] = tx_stb_userbit;
        end else begin
          tx_lanes[i][b] = tx_payload[p];
          p++;
        end
      end
    end
  end

  // Lanes stay quiet until the tx side is online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else if (!tx_online_delay) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_lanes;
    end
  end

  //////////////////////////////////////////////////
  // Receive

  always_ff @(posedge clk_wr) begin
    rx_lanes_q <= rx_phy;
  end

  // Same walk as transmit, userbits dropped
  always_comb begin
    int p;
    p = 0;
    rx_payload = '0;
    for (int i = 0; i < LANE_COUNT; i++) begin
      for (int b = 0; b < LANE_WIDTH; b++) begin
        if (!is_userbit(i, b)) begin
          rx_payload[p] = rx_lanes_q[i][b];
          p++;
        end
      end
    end
  end

  // Marker slot of each received lane
  always_comb begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      rx_mrk[i] = rx_lanes_q[i][MRK_BIT];
    end
  end

  //////////////////////////////////////////////////
  // Checks

  // Persistent marker means all received lanes agree on it
  a_rx_mrk_aligned: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (rx_mrk == '0) || (rx_mrk == '1)
  ) else $error("marker bits differ across received lanes");

endmodule

// ==== lpif_x4_slave_top.sv ====
// Four-lane die-to-die adapter slave top; connects sync, flit pack and lane striping
`timescale 1ns/1ns

module lpif_x4_slave_top (
  input  logic                             clk_wr,
  input  logic                             rst_n,

  // Link control
  input  logic                             tx_online,
  input  logic                             rx_online,

  // Configuration
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_y_value,
  input  logic [lpif_pkg::DELAY_WIDTH-1:0] delay_z_value,
  input  logic                             tx_mrk_userbit,
  input  logic                             tx_stb_userbit,

  // User flits
  input  lpif_pkg::ll_word_t               ustrm,
  output lpif_pkg::ll_word_t               dstrm,

  // PHY lanes
  output lpif_pkg::phy_bus_t               tx_phy,
  input  lpif_pkg::phy_bus_t               rx_phy,

  // Debug status
  output logic [31:0]                      rx_downstream_debug_status,
  output logic [31:0]                      tx_upstream_debug_status
);

  import lpif_pkg::*;

  //////////////////////////////////////////////////
  // Interconnect

  logic     tx_online_delay;
  logic     rx_online_delay;
  logic     tx_auto_mrk_userbit;
  logic     tx_auto_stb_userbit;

  payload_t tx_payload;
  payload_t rx_payload;

  //////////////////////////////////////////////////
  // Auto sync

  ll_auto_sync u_ll_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  //////////////////////////////////////////////////
  // Logic link, FIFOs and credits bypassed

  llink_pack u_llink_pack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_online_delay (rx_online_delay),
    .ustrm           (ustrm),
    .tx_payload      (tx_payload),
    .rx_payload      (rx_payload),
    .dstrm           (dstrm)
  );

  // Bit 19 tx online, bit 18 rx online
  assign rx_downstream_debug_status = {12'h0, tx_online_delay, rx_online_delay, 18'h0};
  assign tx_upstream_debug_status   = {12'h0, tx_online_delay, rx_online_delay, 18'h0};

  //////////////////////////////////////////////////
  // PHY lanes

  lane_stripe u_lane_stripe (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .tx_stb_userbit  (tx_auto_stb_userbit),
    .tx_mrk_userbit  (tx_auto_mrk_userbit),
    .tx_payload      (tx_payload),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .rx_payload      (rx_payload)
  );

endmodule

// ==== tb_clkgen.sv ====
// Testbench clock and reset source; 20 ns clock, reset held low for the first 5 cycles
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int PERIOD_NS    = 20;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release a little after the edge, like every other driven input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

// ==== tb_top.sv ====
// Testbench for the x4 adapter slave; loops tx lanes back to rx and checks with assertions
`timescale 1ns/1ns

module tb_top;

  import lpif_pkg::*;

  //////////////////////////////////////////////////
  // Test list and run length

  localparam int T_RESET   = 0;
  localparam int T_ONLINE  = 1;
  localparam int T_LOOP    = 2;
  localparam int T_USER    = 3;
  localparam int T_RXOFF   = 4;
  localparam int T_OFF     = 5;
  localparam int T_IDLE    = 6;
  localparam int NUM_TESTS = 6;

  localparam int LEN_RESET   = 10;
  localparam int LEN_ONLINE  = 20;
  localparam int LEN_LOOP    = 64;
  localparam int LEN_USER    = 61;
  localparam int LEN_RXOFF   = 24;
  localparam int LEN_OFF     = 8;
  localparam int LEN_TOTAL   = LEN_RESET + LEN_ONLINE + LEN_LOOP + LEN_USER + LEN_RXOFF + LEN_OFF;
  localparam int WATCHDOG_NS = (LEN_TOTAL + 50) * 20;

  logic                   clk_wr;
  logic                   rst_n;
  logic                   tx_online;
  logic                   rx_online;
  logic [DELAY_WIDTH-1:0] delay_x_value;
  logic [DELAY_WIDTH-1:0] delay_y_value;
  logic [DELAY_WIDTH-1:0] delay_z_value;
  logic                   tx_mrk_userbit;
  logic                   tx_stb_userbit;
  ll_word_t               ustrm;
  ll_word_t               dstrm;
  phy_bus_t               tx_phy;
  phy_bus_t               rx_phy;
  logic [31:0]            rx_downstream_debug_status;
  logic [31:0]            tx_upstream_debug_status;

  int          phase;
  int          err_cnt [NUM_TESTS];
  int          tests_passed;
  int          tests_failed;
  logic [31:0] lfsr;

  // Reference model state
  logic [DELAY_WIDTH:0] run_tx;
  logic [DELAY_WIDTH:0] run_rx;
  logic                 exp_tx_on;
  logic                 exp_rx_on;
  logic                 tx_on_d;
  logic                 rx_on_d;
  logic                 mrk_q;
  logic                 stb_en_q;
  logic                 stb_armed;
  int                   stb_gap;
  ll_word_t             hist0;
  ll_word_t             hist1;
  ll_word_t             hist2;
  ll_word_t             exp_flit;
  logic [31:0]          exp_debug;

  tb_clkgen u_clkgen (
    .clk   (clk_wr),
    .rst_n (rst_n)
  );

  lpif_x4_slave_top DUT (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .ustrm                      (ustrm),
    .dstrm                      (dstrm),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status)
  );

  // PHY loopback
  assign rx_phy = tx_phy;

  //////////////////////////////////////////////////
  // Helpers

  function automatic string test_label(input int t);
    case (t)
      T_RESET:  return "reset";
      T_ONLINE: return "online_delay";
      T_LOOP:   return "loopback_data";
      T_USER:   return "userbits";
      T_RXOFF:  return "rx_gating";
      default:  return "go_offline";
    endcase
  endfunction

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = galois_step(lfsr);
    end
  endtask

  task automatic drive_random_flit();
    logic [127:0] r;
    ll_word_t     f;
    take_bits(4, r);
    f.state = r[3:0];
    take_bits(2, r);
    f.protid = r[1:0];
    take_bits(DATA_WIDTH, r);
    f.data = r;
    take_bits(1, r);
    f.dvalid = r[0];
    take_bits(CRC_WIDTH, r);
    f.crc = r[CRC_WIDTH-1:0];
    take_bits(1, r);
    f.crc_valid = r[0];
    take_bits(1, r);
    f.valid = r[0];
    ustrm = f;
  endtask

  task automatic next_cycle();
    @(posedge clk_wr);
    #2;
  endtask

  task automatic run_cycles(input int n, input bit mrk_random);
    logic [127:0] r;
    for (int i = 0; i < n; i++) begin
      drive_random_flit();
      if (mrk_random) begin
        take_bits(1, r);
        tx_mrk_userbit = r[0];
      end
      next_cycle();
    end
  endtask

  task automatic report_mismatch(input string what, input logic [159:0] expected,
                                 input logic [159:0] actual);
    err_cnt[phase]++;
    $display("[FAIL] %s %s: expected %h, actual %h", test_label(phase), what, expected, actual);
  endtask

  task automatic finish_test(input int t);
    if (err_cnt[t] == 0) begin
      tests_passed++;
      $display("test %0d %s: passed", t, test_label(t));
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d mismatches", t, test_label(t), err_cnt[t]);
    end
  endtask

  function automatic ll_word_t strip_flags(input ll_word_t w);
    ll_word_t s;
    s           = w;
    s.valid     = 1'b0;
    s.dvalid    = 1'b0;
    s.crc_valid = 1'b0;
    return s;
  endfunction

  function automatic logic [DELAY_WIDTH:0] count_run(input logic [DELAY_WIDTH:0] run,
                                                     input logic level);
    if (!level) begin
      return '0;
    end
    return (run == '1) ? run : run + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Reference model

  // Online flag rises after delay+1 consecutive high samples
  assign exp_tx_on = run_tx > {1'b0, delay_x_value};
  assign exp_rx_on = run_rx > {1'b0, delay_y_value};
  assign exp_debug = {12'h0, exp_tx_on, exp_rx_on, 18'h0};
  assign exp_flit  = rx_on_d ? hist2 : strip_flags(hist2);

  always @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      run_tx    <= '0;
      run_rx    <= '0;
      tx_on_d   <= 1'b0;
      rx_on_d   <= 1'b0;
      mrk_q     <= 1'b0;
      stb_en_q  <= 1'b0;
      stb_armed <= 1'b0;
      stb_gap   <= 0;
      hist0     <= '0;
      hist1     <= '0;
      hist2     <= '0;
    end else begin
      run_tx   <= count_run(run_tx, tx_online);
      run_rx   <= count_run(run_rx, rx_online);
      tx_on_d  <= exp_tx_on;
      rx_on_d  <= exp_rx_on;
      mrk_q    <= tx_mrk_userbit;
      stb_en_q <= tx_stb_userbit;
      // Three cycles from ustrm to dstrm through the loopback
      hist0 <= ustrm;
      hist1 <= hist0;
      hist2 <= hist1;
      // Edges since the last strobe, restarted while the strobe is disabled
      if (!stb_en_q) begin
        stb_armed <= 1'b0;
        stb_gap   <= 0;
      end else if (tx_phy[STB_LANE][STB_BIT]) begin
        stb_armed <= 1'b1;
        stb_gap   <= 1;
      end else begin
        stb_gap <= stb_gap + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks

  a_reset_quiet: assert property (@(posedge clk_wr)
    phase == T_RESET |-> (tx_phy == '0 && !dstrm.valid &&
                          rx_downstream_debug_status == '0 && tx_upstream_debug_status == '0)
  ) else report_mismatch("quiet outputs", '0, {$sampled(rx_downstream_debug_status),
                         $sampled(tx_upstream_debug_status), 95'(0), $sampled(dstrm.valid)});

  a_debug_words: assert property (@(posedge clk_wr) disable iff (!rst_n)
    phase != T_IDLE |-> (rx_downstream_debug_status == exp_debug &&
                         tx_upstream_debug_status == exp_debug)
  ) else report_mismatch("debug words", {2{$sampled(exp_debug)}},
                         {$sampled(rx_downstream_debug_status),
                          $sampled(tx_upstream_debug_status)});

  a_tx_blank: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (phase != T_IDLE && !tx_on_d) |-> tx_phy == '0
  ) else report_mismatch("tx_phy offline", '0, $sampled(tx_phy));

  a_flit_loop: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (phase == T_LOOP || phase == T_RXOFF) |-> dstrm == exp_flit
  ) else report_mismatch("dstrm flit", 160'($sampled(exp_flit)), 160'($sampled(dstrm)));

  a_rx_flags_low: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (phase == T_RXOFF && !rx_on_d) |-> !(dstrm.valid || dstrm.dvalid || dstrm.crc_valid)
  ) else report_mismatch("valid flags", '0, {$sampled(dstrm.valid), $sampled(dstrm.dvalid),
                         $sampled(dstrm.crc_valid)});

  a_marker: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (phase != T_IDLE && tx_on_d) |->
      {tx_phy[3][MRK_BIT], tx_phy[2][MRK_BIT], tx_phy[1][MRK_BIT], tx_phy[0][MRK_BIT]} ==
      {4{mrk_q}}
  ) else report_mismatch("marker bits", {4{$sampled(mrk_q)}}, {$sampled(tx_phy[3][MRK_BIT]),
                         $sampled(tx_phy[2][MRK_BIT]), $sampled(tx_phy[1][MRK_BIT]),
                         $sampled(tx_phy[0][MRK_BIT])});

  a_stb_disabled: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (phase != T_IDLE && !stb_en_q) |-> !tx_phy[STB_LANE][STB_BIT]
  ) else report_mismatch("strobe while disabled", '0, 1'b1);

  // A strobe lands exactly delay_z_value edges after the previous one
  a_stb_interval: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (phase == T_USER && stb_armed && stb_en_q) |->
      (tx_phy[STB_LANE][STB_BIT] ? stb_gap == delay_z_value : stb_gap < delay_z_value)
  ) else report_mismatch("strobe interval", $sampled(delay_z_value), $sampled(stb_gap));

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    phase          = T_IDLE;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = 16'd5;
    delay_y_value  = 16'd5;
    delay_z_value  = 16'd7;
    tx_mrk_userbit = 1'b1;
    tx_stb_userbit = 1'b0;
    ustrm          = '0;
    lfsr           = 32'd84028;
    tests_passed   = 0;
    tests_failed   = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_cnt[t] = 0;
    end

    // First edge clears the DUT before checking starts
    next_cycle();
    phase = T_RESET;
    run_cycles(LEN_RESET - 1, 1'b0);
    finish_test(T_RESET);

    phase     = T_ONLINE;
    tx_online = 1'b1;
    run_cycles(LEN_ONLINE / 2, 1'b0);
    rx_online = 1'b1;
    run_cycles(LEN_ONLINE / 2, 1'b0);
    finish_test(T_ONLINE);

    phase = T_LOOP;
    run_cycles(LEN_LOOP, 1'b0);
    finish_test(T_LOOP);

    // Strobe every 7, pause, then every 3
    phase          = T_USER;
    tx_stb_userbit = 1'b1;
    run_cycles(36, 1'b1);
    tx_stb_userbit = 1'b0;
    delay_z_value  = 16'd3;
    run_cycles(10, 1'b1);
    tx_stb_userbit = 1'b1;
    run_cycles(15, 1'b1);
    tx_stb_userbit = 1'b0;
    tx_mrk_userbit = 1'b1;
    finish_test(T_USER);

    phase     = T_RXOFF;
    rx_online = 1'b0;
    run_cycles(LEN_RXOFF, 1'b0);
    finish_test(T_RXOFF);

    phase     = T_OFF;
    tx_online = 1'b0;
    run_cycles(LEN_OFF, 1'b0);
    finish_test(T_OFF);

    $display("tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sim.f ====
lpif_pkg.sv
ll_auto_sync.sv
llink_pack.sv
lane_stripe.sv
lpif_x4_slave_top.sv
tb_clkgen.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and check for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_top -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
